// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv_fetch_tb
FILELIST = rv_fetch.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/rv_fetch_pkg.sv ====
`default_nettype none

package rv_fetch_pkg;

  // Address and data width
  localparam int xlen = 32;

  // addi x0, x0, 0
  localparam logic [31:0] i_nop = 32'h0000_0013;

  // Next-PC source
  // Listed lowest to highest priority
  typedef enum logic [1:0] {
    sel_seq      = 2'd0,
    sel_btb      = 2'd1,
    sel_ras      = 2'd2,
    sel_redirect = 2'd3
  } next_pc_sel_e;

  // Prediction state carried with one fetch
  typedef struct packed {
    logic            btb_hit;
    logic            btb_pred_taken;
    logic [xlen-1:0] btb_target;
    logic            btb_is_return;
    logic            ras_valid;
    logic [xlen-1:0] ras_target;
  } pred_t;

  // Bundle handed to decode
  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    pred_t           pred;
  } if_id_t;

  // Redirect strobe from execute
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
  } redirect_t;

  // BTB training strobe from execute
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
    logic            is_call;
    logic            is_return;
  } btb_update_t;

endpackage

`default_nettype wire

// ==== fetch/btb.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb
  import rv_fetch_pkg::*;
#(
  parameter int btb_entries = 16
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [xlen-1:0] pc,
  input  btb_update_t     btb_update,
  output logic            hit,
  output logic            taken,
  output logic [xlen-1:0] target,
  output logic            is_call,
  output logic            is_return
);

  // Word index above the 2 byte-offset bits, tag takes the rest
  localparam int idx_w = $clog2(btb_entries);
  localparam int tag_w = xlen - idx_w - 2;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  target;
    logic             taken;
    logic             is_call;
    logic             is_return;
  } btb_entry_t;

  btb_entry_t             entries [btb_entries];
  logic [btb_entries-1:0] valid;

  logic [idx_w-1:0] rd_idx;
  logic [tag_w-1:0] rd_tag;
  btb_entry_t       rd_entry;
  logic [idx_w-1:0] wr_idx;
  btb_entry_t       wr_entry;

  // Lookup, purely combinational on the fetch PC
  assign rd_idx   = pc[idx_w+1:2];
  assign rd_tag   = pc[xlen-1:idx_w+2];
  assign rd_entry = entries[rd_idx];

  assign hit       = valid[rd_idx] && (rd_entry.tag == rd_tag);
  assign taken     = hit && rd_entry.taken;
  assign target    = rd_entry.target;
  assign is_call   = hit && rd_entry.is_call;
  assign is_return = hit && rd_entry.is_return;

  // Training entry
  assign wr_idx = btb_update.pc[idx_w+1:2];

  always_comb begin
    wr_entry.tag       = btb_update.pc[xlen-1:idx_w+2];
    wr_entry.target    = btb_update.target;
    wr_entry.is_call   = btb_update.is_call;
    wr_entry.is_return = btb_update.is_return;
    // Calls and returns always jump
    // A branch whose target is the fall-through is kept as not taken
    wr_entry.taken = btb_update.is_call || btb_update.is_return ||
                     (btb_update.target != btb_update.pc + xlen'(4));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (btb_update.valid) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (btb_update.valid) begin
      entries[wr_idx] <= wr_entry;
    end
  end

endmodule

`default_nettype wire

// ==== fetch/fetch_sram.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_sram
  import rv_fetch_pkg::*;
#(
  parameter int pipelined = 1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [xlen-1:0] pc,
  input  logic            flush,
  input  logic            id_ready,
  input  pred_t           pred,
  input  logic [31:0]     imem_rdata,
  output logic [31:0]     imem_raddr,
  output logic [31:0]     instr,
  output logic            instr_valid,
  output logic [xlen-1:0] pc_fwd,
  output logic [xlen-1:0] pc_plus4,
  output pred_t           pred_fwd
);

  // Zero-latency SRAM, data returns in the same cycle
  assign imem_raddr = pc;

  if (pipelined != 0) begin : g_buffered
    logic [31:0] instr_buf;
    logic        valid_buf;

    // Capture the returned word when decode accepts
    // Flush drops the slot and leaves a NOP behind
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        instr_buf <= i_nop;
        valid_buf <= 1'b0;
      end else if (flush) begin
        instr_buf <= i_nop;
        valid_buf <= 1'b0;
      end else if (id_ready) begin
        instr_buf <= imem_rdata;
        valid_buf <= 1'b1;
      end
    end

    assign instr       = instr_buf;
    assign instr_valid = valid_buf;
  end else begin : g_comb
    // Straight from memory, valid once out of reset
    assign instr       = imem_rdata;
    assign instr_valid = rst_n;
  end

  // Side fields go on unbuffered
  // The IF/ID register lines them up with the instruction
  assign pc_fwd   = pc;
  assign pc_plus4 = pc + xlen'(4);
  assign pred_fwd = pred;

endmodule

`default_nettype wire

// ==== fetch/pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_gen
  import rv_fetch_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            id_ready,
  input  redirect_t       redirect,
  input  logic            btb_hit,
  input  logic            btb_taken,
  input  logic [xlen-1:0] btb_target,
  input  logic            btb_is_call,
  input  logic            btb_is_return,
  input  logic [xlen-1:0] ras_top,
  input  logic            ras_top_valid,
  output logic [xlen-1:0] pc,
  output logic            ras_push,
  output logic            ras_pop
);

  next_pc_sel_e    next_sel;
  logic [xlen-1:0] next_pc;
  logic            advance;

  // Source select by priority
  // Return only uses the RAS when it holds an entry
  always_comb begin
    if (redirect.valid) begin
      next_sel = sel_redirect;
    end else if (btb_hit && btb_is_return && ras_top_valid) begin
      next_sel = sel_ras;
    end else if (btb_hit && btb_taken) begin
      next_sel = sel_btb;
    end else begin
      next_sel = sel_seq;
    end
  end

  always_comb begin
    case (next_sel)
      sel_redirect: next_pc = redirect.pc;
      sel_ras:      next_pc = ras_top;
      sel_btb:      next_pc = btb_target;
      default:      next_pc = pc + xlen'(4);
    endcase
  end

  // Redirect moves the PC even under back-pressure
  assign advance = id_ready || redirect.valid;

  // Push only when the predicted call is actually followed
  assign ras_push = advance && (next_sel == sel_btb) && btb_is_call;
  assign ras_pop  = advance && (next_sel == sel_ras);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (advance) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== fetch/ras.sv ====
`timescale 1ns/10ps
`default_nettype none

module ras
  import rv_fetch_pkg::*;
#(
  parameter int ras_depth = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [xlen-1:0] pc,
  input  logic            push,
  input  logic            pop,
  output logic [xlen-1:0] top,
  output logic            top_valid
);

  localparam int ptr_w = (ras_depth > 1) ? $clog2(ras_depth) : 1;
  localparam int cnt_w = $clog2(ras_depth + 1);

  logic [xlen-1:0]  stack [ras_depth];
  logic [ptr_w-1:0] top_ptr;
  logic [ptr_w-1:0] ptr_inc;
  logic [ptr_w-1:0] ptr_dec;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic [xlen-1:0]  ret_addr;

  // Return address of the call at pc
  assign ret_addr = pc + xlen'(4);

  // Wrapping pointer steps
  assign ptr_inc = (top_ptr == ptr_w'(ras_depth - 1)) ? '0 : top_ptr + 1'b1;
  assign ptr_dec = (top_ptr == '0) ? ptr_w'(ras_depth - 1) : top_ptr - 1'b1;

  // Push with pop replaces the top in place
  assign wr_ptr = pop ? top_ptr : ptr_inc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else if (push && pop) begin
      if (count == '0) begin
        count <= cnt_w'(1);
      end
    end else if (push) begin
      top_ptr <= ptr_inc;
      // Full stack drops its oldest entry, count saturates
      if (count != cnt_w'(ras_depth)) begin
        count <= count + 1'b1;
      end
    end else if (pop && (count != '0)) begin
      top_ptr <= ptr_dec;
      count   <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack[wr_ptr] <= ret_addr;
    end
  end

  assign top       = stack[top_ptr];
  assign top_valid = (count != '0);

endmodule

`default_nettype wire

// ==== logic/if_id_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module if_id_reg
  import rv_fetch_pkg::*;
#(
  parameter int pipelined = 1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            id_ready,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] pc_plus4,
  input  pred_t           pred,
  output logic [xlen-1:0] pc_q,
  output logic [xlen-1:0] pc_plus4_q,
  output pred_t           pred_q
);

  if (pipelined != 0) begin : g_reg
    logic [xlen-1:0] pc_r;
    logic [xlen-1:0] pc_plus4_r;
    logic [xlen-1:0] btb_target_r;
    logic [xlen-1:0] ras_target_r;
    logic            btb_hit_r;
    logic            btb_taken_r;
    logic            btb_is_return_r;
    logic            ras_valid_r;

    // Prediction flags, cleared so a flushed slot predicts nothing
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        btb_hit_r       <= 1'b0;
        btb_taken_r     <= 1'b0;
        btb_is_return_r <= 1'b0;
        ras_valid_r     <= 1'b0;
      end else if (flush) begin
        btb_hit_r       <= 1'b0;
        btb_taken_r     <= 1'b0;
        btb_is_return_r <= 1'b0;
        ras_valid_r     <= 1'b0;
      end else if (id_ready) begin
        btb_hit_r       <= pred.btb_hit;
        btb_taken_r     <= pred.btb_pred_taken;
        btb_is_return_r <= pred.btb_is_return;
        ras_valid_r     <= pred.ras_valid;
      end
    end

    // Addresses, held under back-pressure
    always_ff @(posedge clk) begin
      if (!flush && id_ready) begin
        pc_r         <= pc;
        pc_plus4_r   <= pc_plus4;
        btb_target_r <= pred.btb_target;
        ras_target_r <= pred.ras_target;
      end
    end

    assign pc_q       = pc_r;
    assign pc_plus4_q = pc_plus4_r;
    assign pred_q     = '{
      btb_hit:        btb_hit_r,
      btb_pred_taken: btb_taken_r,
      btb_target:     btb_target_r,
      btb_is_return:  btb_is_return_r,
      ras_valid:      ras_valid_r,
      ras_target:     ras_target_r
    };
  end else begin : g_pass
    assign pc_q       = pc;
    assign pc_plus4_q = pc_plus4;
    assign pred_q     = pred;
  end

endmodule

`default_nettype wire

// ==== logic/rv_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_top
  import rv_fetch_pkg::*;
#(
  parameter logic [xlen-1:0] reset_pc    = '0,
  parameter int              btb_entries = 16,
  parameter int              ras_depth   = 4,
  parameter int              pipelined   = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        id_ready,
  input  redirect_t   redirect,
  input  btb_update_t btb_update,
  input  logic [31:0] imem_rdata,
  output logic [31:0] imem_raddr,
  output if_id_t      id_out
);

  // Fetch PC and its predictors
  logic [xlen-1:0] pc;
  logic            btb_hit;
  logic            btb_taken;
  logic [xlen-1:0] btb_target;
  logic            btb_is_call;
  logic            btb_is_return;
  logic            ras_push;
  logic            ras_pop;
  logic [xlen-1:0] ras_top;
  logic            ras_top_valid;
  pred_t           pred_if;

  // Fetch stage to IF/ID
  logic [31:0]     instr;
  logic            instr_valid;
  logic [xlen-1:0] pc_fwd;
  logic [xlen-1:0] pc_plus4_fwd;
  pred_t           pred_fwd;

  // IF/ID outputs
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_plus4_q;
  pred_t           pred_q;

  pc_gen #(
    .reset_pc(reset_pc)
  ) u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ready     (id_ready),
    .redirect     (redirect),
    .btb_hit      (btb_hit),
    .btb_taken    (btb_taken),
    .btb_target   (btb_target),
    .btb_is_call  (btb_is_call),
    .btb_is_return(btb_is_return),
    .ras_top      (ras_top),
    .ras_top_valid(ras_top_valid),
    .pc           (pc),
    .ras_push     (ras_push),
    .ras_pop      (ras_pop)
  );

  btb #(
    .btb_entries(btb_entries)
  ) u_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .btb_update(btb_update),
    .hit       (btb_hit),
    .taken     (btb_taken),
    .target    (btb_target),
    .is_call   (btb_is_call),
    .is_return (btb_is_return)
  );

  ras #(
    .ras_depth(ras_depth)
  ) u_ras (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc       (pc),
    .push     (ras_push),
    .pop      (ras_pop),
    .top      (ras_top),
    .top_valid(ras_top_valid)
  );

  // Predictions seen for this fetch
  assign pred_if = '{
    btb_hit:        btb_hit,
    btb_pred_taken: btb_taken,
    btb_target:     btb_target,
    btb_is_return:  btb_is_return,
    ras_valid:      ras_top_valid,
    ras_target:     ras_top
  };

  fetch_sram #(
    .pipelined(pipelined)
  ) u_fetch_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .flush      (redirect.valid),
    .id_ready   (id_ready),
    .pred       (pred_if),
    .imem_rdata (imem_rdata),
    .imem_raddr (imem_raddr),
    .instr      (instr),
    .instr_valid(instr_valid),
    .pc_fwd     (pc_fwd),
    .pc_plus4   (pc_plus4_fwd),
    .pred_fwd   (pred_fwd)
  );

  if_id_reg #(
    .pipelined(pipelined)
  ) u_if_id_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (redirect.valid),
    .id_ready  (id_ready),
    .pc        (pc_fwd),
    .pc_plus4  (pc_plus4_fwd),
    .pred      (pred_fwd),
    .pc_q      (pc_q),
    .pc_plus4_q(pc_plus4_q),
    .pred_q    (pred_q)
  );

  // Instruction and valid come from the fetch stage, the rest from IF/ID
  assign id_out = '{
    valid:    instr_valid,
    instr:    instr,
    pc:       pc_q,
    pc_plus4: pc_plus4_q,
    pred:     pred_q
  };

endmodule

`default_nettype wire

// ==== rv_fetch.f ====
+incdir+verification
common/rv_fetch_pkg.sv
fetch/pc_gen.sv
fetch/btb.sv
fetch/ras.sv
fetch/fetch_sram.sv
logic/if_id_reg.sv
logic/rv_fetch_top.sv
verification/rv_fetch_tb.sv

// ==== verification/rv_fetch_tb_table.svh ====
`ifndef RV_FETCH_TB_TABLE_SVH
`define RV_FETCH_TB_TABLE_SVH

// One row per scenario
// Columns are name, BTB preloads, redirect cycle and target, ready pattern,
// random gap flag and the expected stream of accepted PCs with their sources

localparam int n_rows  = 7;
localparam int max_pre = 4;
localparam int max_exp = 12;

// One BTB training write
typedef struct packed {
  logic [31:0] pc;
  logic [31:0] target;
  logic        is_call;
  logic        is_return;
} preload_t;

// One accepted fetch and how its PC was chosen
typedef struct packed {
  logic [31:0]  pc;
  next_pc_sel_e src;
} expect_t;

string       row_name  [n_rows];
int          n_preload [n_rows];
preload_t    preload   [n_rows][max_pre];
int          redir_cyc [n_rows];
logic [31:0] redir_pc  [n_rows];
logic [15:0] ready_pat [n_rows];
logic        rand_gaps [n_rows];
int          n_exp     [n_rows];
expect_t     exp_tab   [n_rows][max_exp];

// Redirect cycle -1 means no redirect
task automatic define_row(input int r, input string name, input int rc,
                          input logic [31:0] rp, input logic [15:0] pat, input logic rg);
  row_name[r]  = name;
  redir_cyc[r] = rc;
  redir_pc[r]  = rp;
  ready_pat[r] = pat;
  rand_gaps[r] = rg;
  n_preload[r] = 0;
  n_exp[r]     = 0;
endtask

task automatic preload_entry(input int r, input logic [31:0] pc, input logic [31:0] target,
                             input logic call, input logic ret);
  preload[r][n_preload[r]] = '{pc: pc, target: target, is_call: call, is_return: ret};
  n_preload[r]++;
endtask

// First PC comes from src
// Rest of the run is sequential
task automatic expect_run(input int r, input logic [31:0] start, input int count,
                          input next_pc_sel_e src);
  for (int i = 0; i < count; i++) begin
    exp_tab[r][n_exp[r]] = '{pc: start + 32'(4 * i), src: (i == 0) ? src : sel_seq};
    n_exp[r]++;
  end
endtask

// Two nested calls
// Returns come back in reverse order
task automatic call_return_row(input int r, input string name, input logic rg);
  define_row(r, name, -1, 32'h0, 16'hffff, rg);
  preload_entry(r, 32'h0000_1004, 32'h0000_1200, 1'b1, 1'b0);
  preload_entry(r, 32'h0000_1208, 32'h0000_1320, 1'b1, 1'b0);
  preload_entry(r, 32'h0000_1324, 32'h0000_0000, 1'b0, 1'b1);
  preload_entry(r, 32'h0000_1210, 32'h0000_0000, 1'b0, 1'b1);
  expect_run(r, 32'h0000_1000, 2, sel_seq);
  expect_run(r, 32'h0000_1200, 3, sel_btb);
  expect_run(r, 32'h0000_1320, 2, sel_btb);
  expect_run(r, 32'h0000_120c, 2, sel_ras);
  expect_run(r, 32'h0000_1008, 3, sel_ras);
endtask

task automatic build_table();
  define_row(0, "sequential", -1, 32'h0, 16'hffff, 1'b0);
  expect_run(0, 32'h0000_1000, 8, sel_seq);
  define_row(1, "taken_branch", -1, 32'h0, 16'hffff, 1'b0);
  preload_entry(1, 32'h0000_1008, 32'h0000_1040, 1'b0, 1'b0);
  expect_run(1, 32'h0000_1000, 3, sel_seq);
  expect_run(1, 32'h0000_1040, 3, sel_btb);
  call_return_row(2, "call_return", 1'b0);
  // Slot at 100c is flushed
  define_row(3, "redirect", 3, 32'h0000_1800, 16'hffff, 1'b0);
  expect_run(3, 32'h0000_1000, 3, sel_seq);
  expect_run(3, 32'h0000_1800, 3, sel_redirect);
  // Redirect wins over the BTB hit at 1008
  define_row(4, "redirect_over_btb", 2, 32'h0000_1800, 16'hffff, 1'b0);
  preload_entry(4, 32'h0000_1008, 32'h0000_1040, 1'b0, 1'b0);
  expect_run(4, 32'h0000_1000, 2, sel_seq);
  expect_run(4, 32'h0000_1800, 3, sel_redirect);
  define_row(5, "stall_pattern", -1, 32'h0, 16'b1011_0110_1101_1011, 1'b0);
  preload_entry(5, 32'h0000_1008, 32'h0000_1040, 1'b0, 1'b0);
  expect_run(5, 32'h0000_1000, 3, sel_seq);
  expect_run(5, 32'h0000_1040, 5, sel_btb);
  call_return_row(6, "stall_random", 1'b1);
endtask

`endif

// ==== verification/rv_fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_tb
  import rv_fetch_pkg::*;
();

  localparam int          clk_period   = 10;
  localparam int          reset_cycles = 16;
  localparam logic [31:0] reset_pc     = 32'h0000_1000;
  // Memory word is its address scrambled with this key
  localparam logic [31:0] mem_key      = 32'h5a3c_96e1;

  logic        clk;
  logic        rst_n;
  logic        id_ready;
  redirect_t   redirect;
  btb_update_t btb_update;
  logic [31:0] imem_rdata;
  logic [31:0] imem_raddr;
  if_id_t      id_out;

  integer seed = 32'h4557b19c;
  int     errors;
  int     checks;
  int     rows_failed;

  `include "rv_fetch_tb_table.svh"

  // Reset, preloads, twice the longest stream and some slack for each row
  localparam int watchdog_cycles = n_rows * (reset_cycles + max_pre + 2 * max_exp + 24);

  rv_fetch_top #(
    .reset_pc   (reset_pc),
    .btb_entries(16),
    .ras_depth  (4),
    .pipelined  (1)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_ready  (id_ready),
    .redirect  (redirect),
    .btb_update(btb_update),
    .imem_rdata(imem_rdata),
    .imem_raddr(imem_raddr),
    .id_out    (id_out)
  );

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ mem_key;
  endfunction

  // Zero-latency instruction memory
  assign imem_rdata = mem_word(imem_raddr);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  // Checks one bundle taken by decode
  // prev holds the bundle accepted before it
  task automatic check_accepted(input int r, input int k, input if_id_t prev, input int cyc);
    expect_t e;
    e = exp_tab[r][k];
    checks += 3;
    assert (id_out.pc == e.pc)
      else report_mismatch($sformatf("row %0d entry %0d pc %h, expected %h",
                                     r, k, id_out.pc, e.pc));
    assert (id_out.instr == mem_word(id_out.pc))
      else report_mismatch($sformatf("row %0d entry %0d instr %h does not match pc %h",
                                     r, k, id_out.instr, id_out.pc));
    assert (id_out.pc_plus4 == id_out.pc + 32'd4)
      else report_mismatch($sformatf("row %0d entry %0d pc_plus4 %h", r, k, id_out.pc_plus4));
    if (k > 0) begin
      checks++;
      // Source of this PC must show in the predictions of the fetch before it
      case (e.src)
        sel_btb: assert (prev.pred.btb_hit && prev.pred.btb_pred_taken &&
                         prev.pred.btb_target == e.pc)
          else report_mismatch($sformatf("row %0d entry %0d no taken BTB hit to %h",
                                         r, k, e.pc));
        sel_ras: assert (prev.pred.btb_hit && prev.pred.btb_is_return &&
                         prev.pred.ras_valid && prev.pred.ras_target == e.pc)
          else report_mismatch($sformatf("row %0d entry %0d no RAS return to %h",
                                         r, k, e.pc));
        // Target needs the redirect edge and then one more edge
        sel_redirect: assert (redir_cyc[r] >= 0 && cyc >= redir_cyc[r] + 2)
          else report_mismatch($sformatf("row %0d entry %0d target %h ahead of the flush",
                                         r, k, e.pc));
        default: assert (id_out.pc == prev.pc + 32'd4 &&
                         !(prev.pred.btb_hit && prev.pred.btb_pred_taken))
          else report_mismatch($sformatf("row %0d entry %0d not sequential after %h",
                                         r, k, prev.pc));
      endcase
    end
  endtask

  task automatic run_row(input int r);
    if_id_t      prev;
    if_id_t      last;
    logic [31:0] rnd;
    logic [3:0]  pat_idx;
    logic        rdy;
    logic        held;
    int          k;
    int          cyc;
    int          err_start;
    err_start = errors;
    k         = 0;
    cyc       = 0;
    held      = 1'b0;
    prev      = '0;
    last      = '0;
    // Reset with decode stalled
    @(posedge clk);
    rst_n      <= 1'b0;
    id_ready   <= 1'b0;
    redirect   <= '0;
    btb_update <= '0;
    repeat (reset_cycles) begin
      @(negedge clk);
      checks++;
      assert (!id_out.valid)
        else report_mismatch($sformatf("row %0d id_out valid during reset", r));
    end
    @(posedge clk);
    rst_n <= 1'b1;
    // BTB training while the PC waits at reset_pc
    for (int i = 0; i < n_preload[r]; i++) begin
      @(posedge clk);
      btb_update <= '{valid: 1'b1, pc: preload[r][i].pc, target: preload[r][i].target,
                      is_call: preload[r][i].is_call, is_return: preload[r][i].is_return};
    end
    @(posedge clk);
    btb_update <= '0;
    while (k < n_exp[r]) begin
      @(posedge clk);
      pat_idx = 4'(cyc);
      rdy     = ready_pat[r][pat_idx];
      if (rand_gaps[r]) begin
        rnd = $random(seed);
        rdy = rdy && (rnd[1:0] != 2'b00);
      end
      id_ready <= rdy;
      if (cyc == redir_cyc[r]) begin
        redirect <= '{valid: 1'b1, pc: redir_pc[r]};
      end else begin
        redirect <= '0;
      end
      @(negedge clk);
      // Bundle frozen across a stalled edge
      if (held) begin
        checks++;
        assert (id_out === last)
          else report_mismatch($sformatf("row %0d id_out changed under back-pressure", r));
      end
      // Slot behind the redirect edge is dropped
      if (redir_cyc[r] >= 0 && cyc == redir_cyc[r] + 1) begin
        checks++;
        assert (!id_out.valid)
          else report_mismatch($sformatf("row %0d flushed slot shown as valid", r));
      end
      if (id_out.valid && id_ready) begin
        check_accepted(r, k, prev, cyc);
        prev = id_out;
        k++;
      end
      held = !id_ready && !redirect.valid;
      last = id_out;
      cyc++;
    end
    @(posedge clk);
    id_ready <= 1'b0;
    redirect <= '0;
    if (errors == err_start) begin
      $display("scenario %0d %s: ok, %0d entries in %0d cycles", r, row_name[r], k, cyc);
    end else begin
      rows_failed++;
      $display("scenario %0d %s: %0d errors", r, row_name[r], errors - err_start);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    id_ready    = 1'b0;
    redirect    = '0;
    btb_update  = '0;
    errors      = 0;
    checks      = 0;
    rows_failed = 0;
    build_table();
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("%0d scenarios, %0d failed, %0d checks, %0d errors",
             n_rows, rows_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, scenarios did not finish", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
